// File: all.f
src/cache_pkg.sv
src/request_fifo.sv
src/cache_lookup.sv
src/miss_handler.sv
src/memory_arbiter.sv
src/data_cache_top.sv
tb/data_cache_assertions.sv
tb/tb_data_cache.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

top=tb_data_cache
log=sim.log

verilator --binary --timing --assert -f all.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass line only when every check held
if grep -q "^ALL CHECKS PASSED$" "$log"; then
  echo "simulation passed"
  exit 0
fi

echo "pass line not found in $log"
exit 1

// File: src/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup (
  input  logic                         global_bus,
  input  logic                         rst_n,
  input  cache_pkg::cache_req_t        req,
  input  logic                         req_empty,
  output logic                         req_pop,
  output logic                         rsp_valid,
  output cache_pkg::cache_rsp_t        rsp,
  output logic                         miss_valid,
  output logic [cache_pkg::XLEN-1:0]   miss_address,
  input  logic                         refill_valid,
  input  cache_pkg::line_t             refill_line,
  output logic                         wb_push,
  output cache_pkg::wb_record_t        wb_record,
  input  logic                         wb_full
);

  typedef enum logic [1:0] {
    LK_IDLE,
    LK_LOOKUP,
    LK_REFILL
  } lookup_state_e;

  lookup_state_e state_q;
  cache_pkg::cache_req_t stage_q;
  cache_pkg::cache_rsp_t rsp_q;
  logic rsp_valid_q;

  // tag, state and data arrays
  logic [cache_pkg::TAG_BITS-1:0] tag_q [cache_pkg::SETS];
  cache_pkg::cache_state_e line_state_q [cache_pkg::SETS];
  cache_pkg::line_t data_q [cache_pkg::SETS];

  logic [cache_pkg::TAG_BITS-1:0]  tag;
  logic [cache_pkg::SET_BITS-1:0]  set;
  logic [cache_pkg::WORD_BITS-1:0] word;
  logic hit;
  logic victim_dirty;
  cache_pkg::line_t refill_merged;

  // address split of the request held in the stage
  assign tag  = stage_q.address[cache_pkg::XLEN-1 -: cache_pkg::TAG_BITS];
  assign set  = stage_q.address[cache_pkg::WORD_BITS+2 +: cache_pkg::SET_BITS];
  assign word = stage_q.address[2 +: cache_pkg::WORD_BITS];

  assign hit = (line_state_q[set] != cache_pkg::INVALID) && (tag_q[set] == tag);
  assign victim_dirty = (line_state_q[set] == cache_pkg::MODIFIED);

  // a dirty miss waits here until the write buffer has room
  assign miss_valid   = (state_q == LK_LOOKUP) && !hit && !(victim_dirty && wb_full);
  assign miss_address = stage_q.address;
  assign wb_push      = miss_valid && victim_dirty;
  assign wb_record    = '{
    address: {tag_q[set], set, {(cache_pkg::WORD_BITS + 2){1'b0}}},
    line:    data_q[set]
  };

  assign req_pop   = (state_q == LK_IDLE) && !req_empty;
  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  // refilled line with the pending store folded in
  always_comb begin
    refill_merged = refill_line;
    if (stage_q.write) begin
      refill_merged[word] = stage_q.data;
    end
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      state_q     <= LK_IDLE;
      rsp_valid_q <= 1'b0;
      for (int i = 0; i < cache_pkg::SETS; i++) begin
        line_state_q[i] <= cache_pkg::INVALID;
      end
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        LK_IDLE: begin
          if (req_pop) begin
            state_q <= LK_LOOKUP;
          end
        end
        LK_LOOKUP: begin
          if (hit) begin
            rsp_valid_q <= 1'b1;
            state_q     <= LK_IDLE;
            if (stage_q.write) begin
              line_state_q[set] <= cache_pkg::MODIFIED;
            end
          end else if (miss_valid) begin
            state_q <= LK_REFILL;
          end
        end
        LK_REFILL: begin
          if (refill_valid) begin
            rsp_valid_q       <= 1'b1;
            state_q           <= LK_IDLE;
            line_state_q[set] <= stage_q.write ? cache_pkg::MODIFIED : cache_pkg::VALID;
          end
        end
        default: state_q <= LK_IDLE;
      endcase
    end
  end

  // request stage, arrays and response payload
  always_ff @(posedge global_bus) begin
    if (req_pop) begin
      stage_q <= req;
    end
    if (state_q == LK_LOOKUP && hit) begin
      rsp_q.write <= stage_q.write;
      rsp_q.data  <= stage_q.write ? stage_q.data : data_q[set][word];
      if (stage_q.write) begin
        data_q[set][word] <= stage_q.data;
      end
    end
    if (state_q == LK_REFILL && refill_valid) begin
      tag_q[set]  <= tag;
      data_q[set] <= refill_merged;
      rsp_q.write <= stage_q.write;
      rsp_q.data  <= refill_merged[word];
    end
  end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

  // cache geometry
  localparam int XLEN = 32;
  localparam int SETS = 8;
  localparam int WORDS = 4;
  localparam int SET_BITS = 3;
  localparam int WORD_BITS = 2;
  // two address bits are the byte offset inside a word
  localparam int TAG_BITS = XLEN - SET_BITS - WORD_BITS - 2;
  localparam int QUEUE_DEPTH = 4;

  typedef enum logic [1:0] {
    INVALID  = 2'b00,
    VALID    = 2'b01,
    MODIFIED = 2'b10
  } cache_state_e;

  // load/store request from the core
  typedef struct packed {
    logic            write;
    logic [XLEN-1:0] address;
    logic [XLEN-1:0] data;
  } cache_req_t;

  // load data, or the stored word for a store acknowledge
  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            write;
  } cache_rsp_t;

  // word 0 sits at the lowest address of the line
  typedef logic [WORDS-1:0][XLEN-1:0] line_t;

  typedef struct packed {
    logic [XLEN-1:0] address;
    line_t           line;
  } wb_record_t;

  typedef struct packed {
    logic            write;
    logic [XLEN-1:0] address;
    line_t           line;
  } mem_req_t;

endpackage

// File: src/data_cache_top.sv
`timescale 1ns/1ps

module data_cache_top (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp,
  output logic                  mem_valid,
  output cache_pkg::mem_req_t   mem_req,
  input  logic                  mem_ready,
  input  logic                  mem_rsp_valid,
  input  cache_pkg::line_t      mem_rsp_line
);

  // request queue
  cache_pkg::cache_req_t queued_req;
  logic req_full;
  logic req_empty;
  logic req_pop;

  // write buffer
  cache_pkg::wb_record_t wb_record_in;
  cache_pkg::wb_record_t wb_record_out;
  logic wb_push;
  logic wb_pop;
  logic wb_full;
  logic wb_empty;

  // miss and refill path
  logic miss_valid;
  logic [cache_pkg::XLEN-1:0] miss_address;
  logic refill_valid;
  cache_pkg::line_t refill_line;
  logic rd_valid;
  logic [cache_pkg::XLEN-1:0] rd_address;
  logic rd_ready;
  logic rd_rsp_valid;
  cache_pkg::line_t rd_line;

  assign req_ready = !req_full;

  request_fifo #(
    .payload_t(cache_pkg::cache_req_t)
  ) i_request_queue (
    .global_bus(global_bus),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (req_pop),
    .pop_data  (queued_req),
    .full      (req_full),
    .empty     (req_empty)
  );

  cache_lookup i_cache_lookup (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .req         (queued_req),
    .req_empty   (req_empty),
    .req_pop     (req_pop),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .miss_valid  (miss_valid),
    .miss_address(miss_address),
    .refill_valid(refill_valid),
    .refill_line (refill_line),
    .wb_push     (wb_push),
    .wb_record   (wb_record_in),
    .wb_full     (wb_full)
  );

  request_fifo #(
    .payload_t(cache_pkg::wb_record_t)
  ) i_write_buffer (
    .global_bus(global_bus),
    .rst_n     (rst_n),
    .push      (wb_push),
    .push_data (wb_record_in),
    .pop       (wb_pop),
    .pop_data  (wb_record_out),
    .full      (wb_full),
    .empty     (wb_empty)
  );

  miss_handler i_miss_handler (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .miss_valid  (miss_valid),
    .miss_address(miss_address),
    .rd_valid    (rd_valid),
    .rd_address  (rd_address),
    .rd_ready    (rd_ready),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_line     (rd_line),
    .refill_valid(refill_valid),
    .refill_line (refill_line)
  );

  memory_arbiter i_memory_arbiter (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .wb_record    (wb_record_out),
    .wb_empty     (wb_empty),
    .wb_pop       (wb_pop),
    .rd_valid     (rd_valid),
    .rd_address   (rd_address),
    .rd_ready     (rd_ready),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_line      (rd_line),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .mem_ready    (mem_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_line (mem_rsp_line)
  );

endmodule

// File: src/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
  input  logic                       global_bus,
  input  logic                       rst_n,
  input  cache_pkg::wb_record_t      wb_record,
  input  logic                       wb_empty,
  output logic                       wb_pop,
  input  logic                       rd_valid,
  input  logic [cache_pkg::XLEN-1:0] rd_address,
  output logic                       rd_ready,
  output logic                       rd_rsp_valid,
  output cache_pkg::line_t           rd_line,
  output logic                       mem_valid,
  output cache_pkg::mem_req_t        mem_req,
  input  logic                       mem_ready,
  input  logic                       mem_rsp_valid,
  input  cache_pkg::line_t           mem_rsp_line
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_WRITE,
    ARB_READ,
    ARB_WAIT
  } arb_state_e;

  arb_state_e state_q;
  cache_pkg::mem_req_t mem_req_q;

  // request is latched once, so it holds steady until mem_ready
  assign mem_valid = (state_q == ARB_WRITE) || (state_q == ARB_READ);
  assign mem_req   = mem_req_q;

  assign wb_pop       = (state_q == ARB_WRITE) && mem_ready;
  assign rd_ready     = (state_q == ARB_READ) && mem_ready;
  assign rd_rsp_valid = (state_q == ARB_WAIT) && mem_rsp_valid;
  assign rd_line      = mem_rsp_line;

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
    end else begin
      case (state_q)
        // drains first, reads only once the buffer is empty
        ARB_IDLE: begin
          if (!wb_empty) begin
            state_q <= ARB_WRITE;
          end else if (rd_valid) begin
            state_q <= ARB_READ;
          end
        end
        ARB_WRITE: if (mem_ready) state_q <= ARB_IDLE;
        ARB_READ:  if (mem_ready) state_q <= ARB_WAIT;
        ARB_WAIT:  if (mem_rsp_valid) state_q <= ARB_IDLE;
        default:   state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    if (state_q == ARB_IDLE) begin
      if (!wb_empty) begin
        mem_req_q <= '{write: 1'b1, address: wb_record.address, line: wb_record.line};
      end else if (rd_valid) begin
        mem_req_q <= '{write: 1'b0, address: rd_address, line: '0};
      end
    end
  end

endmodule

// File: src/miss_handler.sv
`timescale 1ns/1ps

module miss_handler (
  input  logic                       global_bus,
  input  logic                       rst_n,
  input  logic                       miss_valid,
  input  logic [cache_pkg::XLEN-1:0] miss_address,
  output logic                       rd_valid,
  output logic [cache_pkg::XLEN-1:0] rd_address,
  input  logic                       rd_ready,
  input  logic                       rd_rsp_valid,
  input  cache_pkg::line_t           rd_line,
  output logic                       refill_valid,
  output cache_pkg::line_t           refill_line
);

  typedef enum logic [1:0] {
    MH_IDLE,
    MH_REQUEST,
    MH_WAIT_DATA,
    MH_DELIVER
  } miss_state_e;

  miss_state_e state_q;
  logic [cache_pkg::XLEN-1:0] line_address_q;
  cache_pkg::line_t line_q;

  assign rd_valid     = (state_q == MH_REQUEST);
  assign rd_address   = line_address_q;
  // returned line goes to lookup as a single-cycle pulse
  assign refill_valid = (state_q == MH_DELIVER);
  assign refill_line  = line_q;

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      state_q <= MH_IDLE;
    end else begin
      case (state_q)
        MH_IDLE: begin
          if (miss_valid) begin
            state_q <= MH_REQUEST;
          end
        end
        MH_REQUEST: begin
          if (rd_ready) begin
            state_q <= MH_WAIT_DATA;
          end
        end
        MH_WAIT_DATA: begin
          if (rd_rsp_valid) begin
            state_q <= MH_DELIVER;
          end
        end
        MH_DELIVER: state_q <= MH_IDLE;
        default:    state_q <= MH_IDLE;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    // keep only the line-aligned part of the address
    if (state_q == MH_IDLE && miss_valid) begin
      line_address_q <= {miss_address[cache_pkg::XLEN-1:cache_pkg::WORD_BITS+2],
                         {(cache_pkg::WORD_BITS + 2){1'b0}}};
    end
    if (state_q == MH_WAIT_DATA && rd_rsp_valid) begin
      line_q <= rd_line;
    end
  end

endmodule

// File: src/request_fifo.sv
`timescale 1ns/1ps

module request_fifo #(
  parameter type payload_t = cache_pkg::cache_req_t
) (
  input  logic     global_bus,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     full,
  output logic     empty
);

  payload_t entries [cache_pkg::QUEUE_DEPTH];

  logic [$clog2(cache_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(cache_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(cache_pkg::QUEUE_DEPTH):0]   count;
  logic                                      do_push;
  logic                                      do_pop;

  // requests against a full or empty queue are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == cache_pkg::QUEUE_DEPTH);
  assign empty    = (count == '0);
  assign pop_data = entries[rd_ptr];

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy only moves when exactly one side fires
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage, pointers wrap on the power-of-two depth
  always_ff @(posedge global_bus) begin
    if (do_push) begin
      entries[wr_ptr] <= push_data;
    end
  end

endmodule

// File: tb/cache_vectors.txt
# op address store_data expected, all values hex
# L/S single access, HL load timed as a hit, BL/BS burst with req_valid held high
# cold misses, then a second word of a fetched line
L  00000000 00000000 FFFF0000
L  00000004 00000000 FFFF0004
L  00000020 00000000 FFFF0020
L  0000002C 00000000 FFFF002C
# store then load on a resident line
S  00000024 A5A50001 A5A50001
L  00000024 00000000 A5A50001
L  00000028 00000000 FFFF0028
# hit latency with the pipeline idle
HL 00000020 00000000 FFFF0020
# dirty eviction in set 1 and read back through memory
S  00000018 CAFE0018 CAFE0018
L  00000098 00000000 FFFF0098
L  00000018 00000000 CAFE0018
L  0000001C 00000000 FFFF001C
# burst of misses, evictions and hits
BS 00012340 11110001 11110001
BL 00012344 00000000 FFFE2344
BS 00000054 22220002 22220002
BL 00000060 00000000 FFFF0060
BL 000000A4 00000000 FFFF00A4
BS 000000D0 33330003 33330003
BL 00000054 00000000 22220002
BL 00000024 00000000 A5A50001
BL 00012340 00000000 11110001
BL 000000D0 00000000 33330003
BS 00000064 44440004 44440004
BL 00000064 00000000 44440004

// File: tb/data_cache_assertions.sv
`timescale 1ns/1ps

module data_cache_assertions (
  input logic                global_bus,
  input logic                rst_n,
  input logic                rsp_valid,
  input logic                mem_valid,
  input cache_pkg::mem_req_t mem_req,
  input logic                mem_ready,
  input logic                wb_empty
);

  // a stalled memory request keeps valid and payload
  property mem_request_held;
    @(posedge global_bus) disable iff (!rst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_req);
  endproperty

  property quiet_after_reset;
    @(posedge global_bus) !rst_n |=> !rsp_valid && !mem_valid;
  endproperty

  // refill reads only go out once the write buffer has drained
  property read_after_drain;
    @(posedge global_bus) disable iff (!rst_n)
      mem_valid && !mem_req.write |-> wb_empty;
  endproperty

  assert property (mem_request_held)
    else $error("memory request changed while waiting for mem_ready");

  assert property (quiet_after_reset)
    else $error("rsp_valid or mem_valid high right after reset");

  assert property (read_after_drain)
    else $error("refill read issued with write-backs still buffered");

endmodule

bind data_cache_top data_cache_assertions i_data_cache_assertions (
  .global_bus(global_bus),
  .rst_n     (rst_n),
  .rsp_valid (rsp_valid),
  .mem_valid (mem_valid),
  .mem_req   (mem_req),
  .mem_ready (mem_ready),
  .wb_empty  (wb_empty)
);

// File: tb/tb_data_cache.sv
`timescale 1ns/1ps

module tb_data_cache;

  localparam int ACCEPT_TIMEOUT   = 200;
  localparam int RESPONSE_TIMEOUT = 400;
  // operation tokens as $sscanf leaves them, right aligned
  localparam logic [15:0] OP_STORE       = {8'h00, "S"};
  localparam logic [15:0] OP_HIT_LOAD    = "HL";
  localparam logic [15:0] OP_BURST_LOAD  = "BL";
  localparam logic [15:0] OP_BURST_STORE = "BS";

  typedef struct packed {
    logic [15:0] op;
    logic [31:0] address;
    logic [31:0] data;
    logic [31:0] expected;
  } vector_t;

  logic                  global_bus;
  logic                  rst_n;
  logic                  req_valid;
  cache_pkg::cache_req_t req;
  logic                  req_ready;
  logic                  rsp_valid;
  cache_pkg::cache_rsp_t rsp;
  logic                  mem_valid;
  cache_pkg::mem_req_t   mem_req;
  logic                  mem_ready;
  logic                  mem_rsp_valid;
  cache_pkg::line_t      mem_rsp_line;

  vector_t               vectors[$];
  // write flag, address and expected data of each accepted request
  cache_pkg::cache_req_t expected_q[$];
  logic [31:0]           mem_words [logic [31:0]];
  logic [31:0]           ref_words [logic [31:0]];
  int                    error_count;
  int                    response_count;
  int                    stall_count;
  int                    writeback_count;
  logic                  aborted;

  data_cache_top i_data_cache_top (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req          (req),
    .req_ready    (req_ready),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .mem_ready    (mem_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_line (mem_rsp_line)
  );

  always #5 global_bus = ~global_bus;

  // power-up memory content with the upper address half inverted
  function automatic logic [31:0] initial_word(input logic [31:0] address);
    return {~address[31:16], address[15:0]};
  endfunction

  function automatic logic [31:0] memory_word(input logic [31:0] address);
    if (mem_words.exists(address)) begin
      return mem_words[address];
    end
    return initial_word(address);
  endfunction

  function automatic logic is_store(input logic [15:0] op);
    return (op == OP_STORE) || (op == OP_BURST_STORE);
  endfunction

  function automatic logic is_burst(input logic [15:0] op);
    return (op == OP_BURST_LOAD) || (op == OP_BURST_STORE);
  endfunction

  // last stored value or the initial pattern
  function automatic logic [31:0] model_step(input vector_t v);
    logic [31:0] value;
    if (is_store(v.op)) begin
      ref_words[v.address] = v.data;
      value = v.data;
    end else if (ref_words.exists(v.address)) begin
      value = ref_words[v.address];
    end else begin
      value = initial_word(v.address);
    end
    // vector column must agree with the model
    if (v.expected !== value) begin
      $display("** Error at %0t: vector for 0x%08h expects 0x%08h, model gives 0x%08h",
               $time, v.address, v.expected, value);
      error_count++;
    end
    return value;
  endfunction

  task automatic read_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [15:0] op_text;
    logic [31:0] address;
    logic [31:0] data;
    logic [31:0] expected;
    fd = $fopen("tb/cache_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/cache_vectors.txt");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%s %h %h %h", op_text, address, data, expected);
      if (fields == 4 && line[0] != "#") begin
        vectors.push_back('{op: op_text, address: address, data: data, expected: expected});
      end
    end
    $fclose(fd);
  endtask

  task automatic check_idle_outputs();
    if (rsp_valid !== 1'b0 || mem_valid !== 1'b0 || req_ready !== 1'b1) begin
      $display("** Error at %0t: rsp_valid=%b mem_valid=%b req_ready=%b around reset",
               $time, rsp_valid, mem_valid, req_ready);
      error_count++;
    end
  endtask

  // leaves req_valid high so a burst keeps it asserted
  task automatic send_request(input vector_t v, input logic [31:0] value);
    int waited;
    waited = 0;
    req_valid = 1'b1;
    req = '{write: is_store(v.op), address: v.address, data: v.data};
    @(posedge global_bus);
    while (!req_ready && waited < ACCEPT_TIMEOUT) begin
      stall_count++;
      waited++;
      @(posedge global_bus);
    end
    if (req_ready) begin
      expected_q.push_back('{write: is_store(v.op), address: v.address, data: value});
    end else begin
      $display("timeout: request to 0x%08h was never accepted", v.address);
      aborted = 1'b1;
    end
    #1;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < RESPONSE_TIMEOUT) begin
      @(posedge global_bus);
      #1;
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("timeout: %0d responses never arrived", expected_q.size());
      aborted = 1'b1;
    end
  endtask

  // counts edges from the accepting edge until rsp_valid shows
  task automatic check_hit_latency(input vector_t v, input logic [31:0] value);
    int cycles;
    send_request(v, value);
    req_valid = 1'b0;
    cycles = 0;
    while (!rsp_valid && cycles < ACCEPT_TIMEOUT) begin
      @(posedge global_bus);
      #1;
      cycles++;
    end
    if (cycles != 2) begin
      $display("** Error at %0t: hit on 0x%08h took %0d cycles, expected 2",
               $time, v.address, cycles);
      error_count++;
    end
  endtask

  always @(posedge global_bus) begin : response_monitor
    cache_pkg::cache_req_t expected;
    if (rst_n && rsp_valid) begin
      if (expected_q.size() == 0) begin
        $display("a response arrived at %0t with no request outstanding", $time);
        error_count++;
      end else begin
        expected = expected_q.pop_front();
        response_count++;
        if (rsp.write !== expected.write || rsp.data !== expected.data) begin
          $display("** Error at %0t: access 0x%08h (write %0b) returned 0x%08h, expected 0x%08h",
                   $time, expected.address, expected.write, rsp.data, expected.data);
          error_count++;
        end
      end
    end
  end

  // line-wide memory with random accept and return delays
  initial begin : memory_model
    cache_pkg::mem_req_t taken;
    int                  delay;
    void'($urandom(88977));
    forever begin
      @(posedge global_bus);
      if (rst_n && mem_valid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge global_bus);
        #1 mem_ready = 1'b1;
        @(posedge global_bus);
        taken = mem_req;
        #1 mem_ready = 1'b0;
        if (taken.write) begin
          writeback_count++;
          for (int k = 0; k < cache_pkg::WORDS; k++) begin
            mem_words[taken.address + 4 * k] = taken.line[k];
          end
        end else begin
          delay = $urandom_range(4, 1);
          repeat (delay - 1) begin
            @(posedge global_bus);
            #1;
          end
          for (int k = 0; k < cache_pkg::WORDS; k++) begin
            mem_rsp_line[k] = memory_word(taken.address + 4 * k);
          end
          mem_rsp_valid = 1'b1;
          @(posedge global_bus);
          #1 mem_rsp_valid = 1'b0;
        end
      end
    end
  end

  initial begin
    vector_t     v;
    logic [31:0] value;
    int          i;
    global_bus      = 1'b0;
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    mem_ready       = 1'b0;
    mem_rsp_valid   = 1'b0;
    mem_rsp_line    = '0;
    error_count     = 0;
    response_count  = 0;
    stall_count     = 0;
    writeback_count = 0;
    aborted         = 1'b0;
    read_vectors();
    if (vectors.size() == 0) begin
      $display("no vectors were read");
      aborted = 1'b1;
    end

    repeat (16) begin
      @(posedge global_bus);
      #1;
      check_idle_outputs();
    end
    rst_n = 1'b1;
    @(posedge global_bus);
    #1;
    check_idle_outputs();

    i = 0;
    while (i < vectors.size() && !aborted) begin
      if (is_burst(vectors[i].op)) begin
        stall_count = 0;
        while (i < vectors.size() && is_burst(vectors[i].op) && !aborted) begin
          v = vectors[i];
          value = model_step(v);
          send_request(v, value);
          i++;
        end
        req_valid = 1'b0;
        wait_responses();
        if (stall_count == 0) begin
          $display("the burst never saw req_ready drop");
          error_count++;
        end
      end else begin
        v = vectors[i];
        value = model_step(v);
        if (v.op == OP_HIT_LOAD) begin
          check_hit_latency(v, value);
        end else begin
          send_request(v, value);
          req_valid = 1'b0;
        end
        wait_responses();
        i++;
      end
    end

    if (!aborted && response_count != vectors.size()) begin
      $display("%0d responses for %0d requests", response_count, vectors.size());
      error_count++;
    end
    if (writeback_count == 0) begin
      $display("no dirty line was ever written back");
      error_count++;
    end
    // a written-back word must match its last store
    foreach (ref_words[a]) begin
      if (mem_words.exists(a) && mem_words[a] !== ref_words[a]) begin
        $display("** Error at %0t: memory word 0x%08h holds 0x%08h, expected 0x%08h",
                 $time, a, mem_words[a], ref_words[a]);
        error_count++;
      end
    end

    $display("errors: %0d, responses checked: %0d, write-backs: %0d",
             error_count, response_count, writeback_count);
    if (error_count == 0 && !aborted) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
